//--- rtl/cpuPkg.sv
package cpuPkg;

    // Data and address word
    typedef logic [31:0] wordT;

    // Raw instruction word
    typedef logic [31:0] instT;

    // Register index, x0..x31
    typedef logic [4:0] regAddrT;

    localparam int REG_COUNT = 32;

    // ALU operations for the supported subset
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpT;

    // Major opcodes
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 values
    localparam logic [2:0] F3_ADDSUB = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_WORD   = 3'b010;  // lw, sw
    localparam logic [2:0] F3_BEQ    = 3'b000;

    // Instruction memory, word addressed
    localparam int IMEM_WORDS     = 64;
    localparam int IMEM_ADDR_BITS = 6;

    // Data memory, word addressed
    localparam int DMEM_WORDS     = 64;
    localparam int DMEM_ADDR_BITS = 6;

endpackage

//--- rtl/instFetch.sv
`timescale 1ns/1ps

module instFetch import cpuPkg::*; (
    input  logic                      CLK,
    input  logic                      reset,
    input  logic                      run,
    input  logic                      imemWrite,
    input  logic [IMEM_ADDR_BITS-1:0] imemAddr,
    input  instT                      imemData,
    input  logic                      branchTaken,
    input  wordT                      branchOffset,
    output wordT                      pc,
    output instT                      instruction
);

    instT imem [IMEM_WORDS];  // Program storage, no reset

    wordT seqPc;
    wordT targetPc;
    wordT nextPc;
    logic [IMEM_ADDR_BITS-1:0] fetchIndex;

    assign seqPc    = pc + 32'd4;
    assign targetPc = pc + branchOffset;  // Offset already carries bit 0 = 0
    assign nextPc   = branchTaken ? targetPc : seqPc;

    // Word index from the byte PC
    assign fetchIndex  = pc[IMEM_ADDR_BITS+1:2];
    assign instruction = imem[fetchIndex];

    // Program counter holds while halted
    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // Load port is only open while the core is halted
    always_ff @(posedge CLK) begin
        if (imemWrite && !run) begin
            imem[imemAddr] <= imemData;
        end
    end

endmodule

//--- rtl/decodeControl.sv
`timescale 1ns/1ps

module decodeControl import cpuPkg::*; (
    input  instT    instruction,
    output regAddrT rs1,
    output regAddrT rs2,
    output regAddrT rd,
    output wordT    immediate,
    output logic    regWrite,
    output logic    aluSrc,
    output logic    memWrite,
    output logic    memToReg,
    output logic    branch,
    output aluOpT   aluOp
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    wordT immI;
    wordT immS;
    wordT immB;

    assign opcode   = instruction[6:0];
    assign funct3   = instruction[14:12];
    assign funct7b5 = instruction[30];  // Selects sub over add

    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];
    assign rd  = instruction[11:7];

    // Sign-extended immediates per format
    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};

    always_comb begin
        // Safe defaults, nothing gets written
        regWrite  = 1'b0;
        aluSrc    = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        aluOp     = ALU_ADD;
        immediate = immI;

        case (opcode)
            OP_RTYPE: begin
                regWrite = 1'b1;
                case (funct3)
                    F3_ADDSUB: aluOp = funct7b5 ? ALU_SUB : ALU_ADD;
                    F3_SLT:    aluOp = ALU_SLT;
                    F3_OR:     aluOp = ALU_OR;
                    F3_AND:    aluOp = ALU_AND;
                    default:   regWrite = 1'b0;  // Not in the subset
                endcase
            end
            OP_ITYPE: begin
                aluSrc   = 1'b1;
                regWrite = (funct3 == F3_ADDSUB);  // addi only
            end
            OP_LOAD: begin
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                regWrite = (funct3 == F3_WORD);
            end
            OP_STORE: begin
                aluSrc    = 1'b1;
                immediate = immS;
                memWrite  = (funct3 == F3_WORD);
            end
            OP_BRANCH: begin
                immediate = immB;
                aluOp     = ALU_SUB;  // Zero flag gives equality
                branch    = (funct3 == F3_BEQ);
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
    input  logic    CLK,
    input  logic    reset,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  regAddrT rd,
    input  logic    writeEnable,
    input  wordT    writeData,
    output wordT    readData1,
    output wordT    readData2
);

    wordT regs [REG_COUNT];

    // x0 always reads zero
    assign readData1 = (rs1 == '0) ? '0 : regs[rs1];
    assign readData2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && rd != '0) begin
            regs[rd] <= writeData;
        end
    end

endmodule

//--- rtl/aluExecute.sv
`timescale 1ns/1ps

module aluExecute import cpuPkg::*; (
    input  wordT  operandA,
    input  wordT  registerB,
    input  wordT  immediate,
    input  logic  aluSrc,
    input  aluOpT aluOp,
    input  logic  branch,
    output wordT  aluResult,
    output logic  branchTaken
);

    wordT operandB;
    logic zero;

    // Immediate for I and S formats, register otherwise
    assign operandB = aluSrc ? immediate : registerB;

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = operandA + operandB;
            ALU_SUB: aluResult = operandA - operandB;
            ALU_AND: aluResult = operandA & operandB;
            ALU_OR:  aluResult = operandA | operandB;
            ALU_SLT: begin
                // Signed compare
                aluResult = ($signed(operandA) < $signed(operandB)) ? 32'd1 : 32'd0;
            end
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // beq decodes to sub, so zero means equal operands
    assign branchTaken = branch && zero;

endmodule

//--- rtl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory import cpuPkg::*; (
    input  logic CLK,
    input  logic reset,
    input  wordT address,
    input  logic writeEnable,
    input  wordT storeData,
    input  wordT aluResult,
    input  logic memToReg,
    output wordT writeBack
);

    wordT mem [DMEM_WORDS];

    logic [DMEM_ADDR_BITS-1:0] wordIndex;

    assign wordIndex = address[DMEM_ADDR_BITS+1:2];  // Byte offset dropped

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEnable) begin
            mem[wordIndex] <= storeData;
        end
    end

    // Loaded word for lw, ALU result otherwise
    assign writeBack = memToReg ? mem[wordIndex] : aluResult;

endmodule

//--- rtl/singleCpu.sv
`timescale 1ns/1ps

module singleCpu import cpuPkg::*; (
    input  logic                      CLK,
    input  logic                      reset,
    input  logic                      run,
    input  logic                      imemWrite,
    input  logic [IMEM_ADDR_BITS-1:0] imemAddr,
    input  instT                      imemData,
    output wordT                      pc,
    output instT                      instruction,
    output logic                      regWriteValid,
    output regAddrT                   regWriteAddr,
    output wordT                      regWriteData,
    output logic                      memWriteValid,
    output wordT                      memWriteAddr,
    output wordT                      memWriteData
);

    regAddrT rs1;
    regAddrT rs2;
    regAddrT rd;
    wordT    immediate;
    logic    regWrite;
    logic    aluSrc;
    logic    memWrite;
    logic    memToReg;
    logic    branch;
    aluOpT   aluOp;

    wordT readData1;
    wordT readData2;
    wordT aluResult;
    wordT writeBack;
    logic branchTaken;

    logic regWriteEn;
    logic memWriteEn;

    // Nothing commits while halted
    assign regWriteEn = regWrite && run;
    assign memWriteEn = memWrite && run;

    instFetch u_instFetch (
        .CLK          (CLK),
        .reset        (reset),
        .run          (run),
        .imemWrite    (imemWrite),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .branchTaken  (branchTaken),
        .branchOffset (immediate),
        .pc           (pc),
        .instruction  (instruction)
    );

    decodeControl u_decodeControl (
        .instruction (instruction),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .immediate   (immediate),
        .regWrite    (regWrite),
        .aluSrc      (aluSrc),
        .memWrite    (memWrite),
        .memToReg    (memToReg),
        .branch      (branch),
        .aluOp       (aluOp)
    );

    registerFile u_registerFile (
        .CLK         (CLK),
        .reset       (reset),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .writeEnable (regWriteEn),
        .writeData   (writeBack),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    aluExecute u_aluExecute (
        .operandA    (readData1),
        .registerB   (readData2),
        .immediate   (immediate),
        .aluSrc      (aluSrc),
        .aluOp       (aluOp),
        .branch      (branch),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    dataMemory u_dataMemory (
        .CLK         (CLK),
        .reset       (reset),
        .address     (aluResult),
        .writeEnable (memWriteEn),
        .storeData   (readData2),
        .aluResult   (aluResult),
        .memToReg    (memToReg),
        .writeBack   (writeBack)
    );

    // Commit reporting, x0 writes are not reported
    assign regWriteValid = regWriteEn && (rd != '0);
    assign regWriteAddr  = rd;
    assign regWriteData  = writeBack;

    assign memWriteValid = memWriteEn;
    assign memWriteAddr  = aluResult;  // Byte address of the stored word
    assign memWriteData  = readData2;

endmodule

//--- bench/tbChecker.sv
`timescale 1ns/1ps

module tbChecker import cpuPkg::*; (
    input  logic    CLK,
    input  logic    reset,
    input  logic    run,
    input  wordT    pc,
    input  instT    instruction,
    input  logic    regWriteValid,
    input  regAddrT regWriteAddr,
    input  wordT    regWriteData,
    input  logic    memWriteValid,
    input  wordT    memWriteAddr,
    input  wordT    memWriteData,
    output logic    allSeen,
    output int      pendingEvents,
    output int      testsPassed,
    output int      testsFailed,
    output int      errorCount
);

    localparam string      GOLDEN_FILE  = "bench/cpuGolden.txt";
    localparam int         GOLDEN_DEPTH = 128;
    localparam logic [3:0] TAG_INST     = 4'h1;
    localparam logic [3:0] TAG_REG      = 4'h2;
    localparam logic [3:0] TAG_MEM      = 4'h3;
    localparam logic [3:0] TAG_TEST     = 4'h4;
    localparam logic [3:0] TAG_END      = 4'hF;

    logic [67:0] golden [GOLDEN_DEPTH];
    logic [67:0] expected [$];  // R, M and T entries in file order
    int          testErrors;    // Since the last test marker

    instT        progWords [IMEM_WORDS];  // Loaded program by word index
    logic        loaded [IMEM_WORDS];
    wordT        prevPc;
    instT        prevInst;
    logic        prevValid;

    task automatic noteError();
        errorCount++;
        testErrors++;
    endtask

    // Fetch side of the core against the loaded program
    task automatic checkFetch();
        logic [IMEM_ADDR_BITS-1:0] index;
        index = pc[IMEM_ADDR_BITS+1:2];
        if (!run) begin
            if (pc != '0) begin
                $display("[ERROR] %0t: pc = %h while halted, expected 00000000", $time, pc);
                noteError();
            end
            if (regWriteValid || memWriteValid) begin
                $display("A write was reported at %0t while the core was halted", $time);
                noteError();
            end
            prevValid = 1'b0;
        end else begin
            // Only beq may leave the sequential path
            if (prevValid && prevInst[6:0] != OP_BRANCH && pc != prevPc + 32'd4) begin
                $display("[ERROR] %0t: pc = %h after %h at pc %h, expected %h",
                         $time, pc, prevInst, prevPc, prevPc + 32'd4);
                noteError();
            end
            prevValid = 1'b0;
            if (pc[1:0] != 2'b00 || pc >= 4 * IMEM_WORDS || !loaded[index]) begin
                $display("Fetch from pc %h at %0t, where no program word was loaded",
                         pc, $time);
                noteError();
            end else begin
                if (instruction != progWords[index]) begin
                    $display("[ERROR] %0t: instruction %h at pc %h, expected %h",
                             $time, instruction, pc, progWords[index]);
                    noteError();
                end
                prevPc    = pc;
                prevInst  = progWords[index];
                prevValid = 1'b1;
            end
        end
    endtask

    task automatic checkRegWrite();
        logic [67:0] entry;
        if (expected.size() == 0 || expected[0][67:64] != TAG_REG) begin
            $display("Register write x%0d = %h at %0t was not expected at this point",
                     regWriteAddr, regWriteData, $time);
            noteError();
        end else begin
            entry = expected.pop_front();
            if (regWriteAddr != entry[36:32] || regWriteData != entry[31:0]) begin
                $display("[ERROR] %0t: register write x%0d = %h, expected x%0d = %h",
                         $time, regWriteAddr, regWriteData, entry[36:32], entry[31:0]);
                noteError();
            end
        end
    endtask

    task automatic checkMemWrite();
        logic [67:0] entry;
        if (expected.size() == 0 || expected[0][67:64] != TAG_MEM) begin
            $display("Memory write [%h] = %h at %0t was not expected at this point",
                     memWriteAddr, memWriteData, $time);
            noteError();
        end else begin
            entry = expected.pop_front();
            if (memWriteAddr != entry[63:32] || memWriteData != entry[31:0]) begin
                $display("[ERROR] %0t: memory write [%h] = %h, expected [%h] = %h",
                         $time, memWriteAddr, memWriteData, entry[63:32], entry[31:0]);
                noteError();
            end
        end
    endtask

    // Test markers that reach the head of the queue close their test
    task automatic closeTests();
        logic [67:0] entry;
        while (expected.size() > 0 && expected[0][67:64] == TAG_TEST) begin
            entry = expected.pop_front();
            if (testErrors == 0) begin
                testsPassed++;
                $display("Test %0d passed at %0t", entry[63:32], $time);
            end else begin
                testsFailed++;
                $display("Test %0d failed with %0d errors", entry[63:32], testErrors);
            end
            testErrors = 0;
        end
    endtask

    initial begin
        errorCount  = 0;
        testsPassed = 0;
        testsFailed = 0;
        testErrors  = 0;
        prevValid   = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            loaded[i] = 1'b0;
        end
        $readmemh(GOLDEN_FILE, golden);
        for (int i = 0; i < GOLDEN_DEPTH; i++) begin
            if (golden[i][67:64] == TAG_END) begin
                break;
            end
            if (golden[i][67:64] == TAG_INST) begin
                progWords[golden[i][32 +: IMEM_ADDR_BITS]] = golden[i][31:0];
                loaded[golden[i][32 +: IMEM_ADDR_BITS]]    = 1'b1;
            end else begin
                expected.push_back(golden[i]);
            end
        end
        pendingEvents = expected.size();
        allSeen       = (pendingEvents == 0);

        // Strobes are sampled before the edge updates any state
        forever begin
            @(posedge CLK);
            if (!reset) begin
                checkFetch();
            end
            if (regWriteValid) begin
                checkRegWrite();
            end
            if (memWriteValid) begin
                checkMemWrite();
            end
            closeTests();
            pendingEvents = expected.size();
            allSeen       = (pendingEvents == 0);
        end
    end

endmodule

//--- bench/tbTop.sv
`timescale 1ns/1ps

module tbTop import cpuPkg::*; ();

    localparam string      GOLDEN_FILE  = "bench/cpuGolden.txt";
    localparam int         GOLDEN_DEPTH = 128;
    localparam int         RESET_CYCLES = 5;
    localparam logic [3:0] TAG_INST     = 4'h1;
    localparam logic [3:0] TAG_END      = 4'hF;

    logic                      CLK;
    logic                      reset;
    logic                      run;
    logic                      imemWrite;
    logic [IMEM_ADDR_BITS-1:0] imemAddr;
    instT                      imemData;

    wordT    pc;
    instT    instruction;
    logic    regWriteValid;
    regAddrT regWriteAddr;
    wordT    regWriteData;
    logic    memWriteValid;
    wordT    memWriteAddr;
    wordT    memWriteData;

    // Checker status
    logic allSeen;
    int   pendingEvents;
    int   testsPassed;
    int   testsFailed;
    int   errorCount;

    logic [67:0] golden [GOLDEN_DEPTH];  // Tag, field1, field2
    int          programWords;
    int          cycleLimit;
    int          runCycles;

    singleCpu i_dut (.*);

    tbChecker u_checker (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // One program word per rising edge while the core is halted
    task automatic loadProgram();
        programWords = 0;
        for (int i = 0; i < GOLDEN_DEPTH; i++) begin
            if (golden[i][67:64] == TAG_END) begin
                break;
            end
            if (golden[i][67:64] == TAG_INST) begin
                @(posedge CLK);
                imemWrite <= 1'b1;
                imemAddr  <= golden[i][32 +: IMEM_ADDR_BITS];
                imemData  <= golden[i][31:0];
                programWords++;
            end
        end
        @(posedge CLK);
        imemWrite <= 1'b0;
    endtask

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        imemWrite = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        $readmemh(GOLDEN_FILE, golden);

        repeat (RESET_CYCLES) @(posedge CLK);
        reset <= 1'b0;
        loadProgram();
        cycleLimit = 2 * programWords + 20;

        @(posedge CLK);
        run <= 1'b1;

        // Status is read on the falling edge, after the checker has updated it
        runCycles = 0;
        while (!allSeen && runCycles < cycleLimit) begin
            @(negedge CLK);
            runCycles++;
        end
        repeat (2) @(negedge CLK);  // Catch a stray commit after the last event

        if (programWords == 0) begin
            $display("No program words were found in %s", GOLDEN_FILE);
        end
        if (!allSeen) begin
            $display("Timeout after %0d cycles, %0d expected entries were never seen",
                     runCycles, pendingEvents);
        end
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 testsPassed, testsFailed, errorCount);
        if (allSeen && programWords > 0 && testsPassed > 0 && testsFailed == 0
                && errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- bench/cpuGolden.txt
// Entries are tag_field1_field2 in hex. Tag 1 program word (word index, instruction), 2 register
// write (index, value), 3 memory write (byte address, value), 4 end of test (number), F end
1_00000000_00700093 2_00000001_00000007                      // addi x1, x0, 7
1_00000001_FFD00113 2_00000002_FFFFFFFD                      // addi x2, x0, -3
1_00000002_002081B3 2_00000003_00000004                      // add  x3, x1, x2
1_00000003_40208233 2_00000004_0000000A                      // sub  x4, x1, x2
1_00000004_0020F2B3 2_00000005_00000005                      // and  x5, x1, x2
1_00000005_0020E333 2_00000006_FFFFFFFF                      // or   x6, x1, x2
1_00000006_001123B3 2_00000007_00000001                      // slt  x7, x2, x1
1_00000007_0020A433 2_00000008_00000000 4_00000001_00000000  // slt  x8, x1, x2  (test 1 ends)
1_00000008_80000493 2_00000009_FFFFF800                      // addi x9, x0, -2048
1_00000009_FFF48513 2_0000000A_FFFFF7FF                      // addi x10, x9, -1
1_0000000A_7FF50593 2_0000000B_FFFFFFFE 4_00000002_00000000  // addi x11, x10, 2047  (test 2 ends)
1_0000000B_04000613 2_0000000C_00000040                      // addi x12, x0, 64
1_0000000C_00662423 3_00000048_FFFFFFFF                      // sw   x6, 8(x12)
1_0000000D_00462623 3_0000004C_0000000A                      // sw   x4, 12(x12)
1_0000000E_00862683 2_0000000D_FFFFFFFF                      // lw   x13, 8(x12)
1_0000000F_00C62703 2_0000000E_0000000A                      // lw   x14, 12(x12)
1_00000010_FE962E23 3_0000003C_FFFFF800                      // sw   x9, -4(x12)
1_00000011_FFC62783 2_0000000F_FFFFF800 4_00000003_00000000  // lw   x15, -4(x12)  (test 3 ends)
1_00000012_00108463                                          // beq  x1, x1, +8 taken
1_00000013_06300813                                          // addi x16, x0, 99 is skipped
1_00000014_00500893 2_00000011_00000005                      // addi x17, x0, 5
1_00000015_00208463                                          // beq  x1, x2, +8 not taken
1_00000016_00600913 2_00000012_00000006 4_00000004_00000000  // addi x18, x0, 6  (test 4 ends)
1_00000017_07B00013                                          // addi x0, x0, 123
1_00000018_00108033                                          // add  x0, x1, x1
1_00000019_002009B3 2_00000013_FFFFFFFD                      // add  x19, x0, x2
1_0000001A_00008A33 2_00000014_00000007 4_00000005_00000000  // add  x20, x1, x0  (test 5 ends)
1_0000001B_00000063 F_00000000_00000000                      // beq  x0, x0, 0 holds the core

//--- filelist.f
rtl/cpuPkg.sv
rtl/instFetch.sv
rtl/decodeControl.sv
rtl/registerFile.sv
rtl/aluExecute.sv
rtl/dataMemory.sv
rtl/singleCpu.sv
bench/tbChecker.sv
bench/tbTop.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tbTop
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG) and check it"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx '>>> PASS' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
